/* timer_config.svh */
// Timer build configuration
`ifndef TIMER_CONFIG_SVH
`define TIMER_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Bus widths
////////////////////////////////////////////////////////////////////////////

// AHB address and data widths
`define TIMER_ADDR_W 32
`define TIMER_DATA_W 32

////////////////////////////////////////////////////////////////////////////
// Timer sizing
////////////////////////////////////////////////////////////////////////////

// Number of compare channels
`define TIMER_NUM 3

// Time and compare register width
`define TIMER_TIME_W 64

////////////////////////////////////////////////////////////////////////////
// Register map
////////////////////////////////////////////////////////////////////////////

`define TIMER_OFS_PRESCALE 'h00
`define TIMER_OFS_RESERVED 'h04
`define TIMER_OFS_IPENDING 'h08
`define TIMER_OFS_IENABLE  'h0C
`define TIMER_OFS_TIME     'h10
// Compare n sits at this offset plus 8*n
`define TIMER_OFS_TIMECMP  'h18

`endif

/* timer_pkg.sv */
// Timer shared types
`include "timer_config.svh"

package timer_pkg;

  // One bus data word
  typedef logic [`TIMER_DATA_W-1:0] word_t;

  // Time and compare values
  typedef logic [`TIMER_TIME_W-1:0] time_t;

  // One enable per byte lane
  typedef logic [`TIMER_DATA_W/8-1:0] byte_en_t;

  // Compare index, at least one bit wide
  localparam int TIMER_IDX_W = (`TIMER_NUM > 1) ? $clog2(`TIMER_NUM) : 1;
  typedef logic [TIMER_IDX_W-1:0] timer_idx_t;

  // One bit per compare channel
  typedef logic [`TIMER_NUM-1:0] timer_mask_t;

  // Decoded register target
  typedef enum logic [2:0] {
    SEL_NONE     = 3'd0,
    SEL_PRESCALE = 3'd1,
    SEL_IPENDING = 3'd2,
    SEL_IENABLE  = 3'd3,
    SEL_TIME_LO  = 3'd4,
    SEL_TIME_HI  = 3'd5,
    SEL_TIMECMP  = 3'd6
  } reg_sel_e;

  // HTRANS codes
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_BUSY   = 2'b01;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  // HSIZE codes up to bus width
  localparam logic [2:0] HSIZE_BYTE  = 3'b000;
  localparam logic [2:0] HSIZE_HWORD = 3'b001;
  localparam logic [2:0] HSIZE_WORD  = 3'b010;

endpackage : timer_pkg

/* timer_regbus_if.sv */
// Timer register access bus
`timescale 1ns/1ps

interface timer_regbus_if;
  import timer_pkg::*;

  // Access in its data phase, from decode
  logic       wr;
  logic       rd;
  reg_sel_e   sel;
  timer_idx_t idx;
  // Upper half of a 64-bit register
  logic       hi;
  byte_en_t   be;
  word_t      wdata;

  // Register file view, from execute
  word_t      rdata;
  logic       irq_any;

  // Decoder side
  modport dec (
    output wr, rd, sel, idx, hi, be, wdata
  );

  // Register file side
  modport exe (
    input  wr, sel, idx, hi, be, wdata,
    output rdata, irq_any
  );

  // Response side
  modport res (
    input rd, rdata, irq_any
  );

endinterface : timer_regbus_if

/* ahb_timer_decode.sv */
// AHB address phase decoder
`timescale 1ns/1ps
`include "timer_config.svh"

module ahb_timer_decode (
  input  logic                     HCLK,
  input  logic                     HRESETn,
  input  logic                     HSEL,
  input  logic [`TIMER_ADDR_W-1:0] HADDR,
  input  timer_pkg::word_t         HWDATA,
  input  logic                     HWRITE,
  input  logic [2:0]               HSIZE,
  input  logic [1:0]               HTRANS,
  input  logic                     HREADY,
  timer_regbus_if.dec              bus
);
  import timer_pkg::*;

  // Block decodes a 4 KiB window that HSEL selects
  localparam int DEC_W = 12;

  logic             xfer;
  logic [DEC_W-1:0] ofs;
  logic [DEC_W-1:0] cmp_ofs;
  logic [DEC_W-4:0] cmp_num;
  reg_sel_e         sel_d;

  // Address phase captured on HREADY
  logic             wr_q;
  logic             rd_q;
  reg_sel_e         sel_q;
  timer_idx_t       idx_q;
  logic             hi_q;
  byte_en_t         be_q;

  // Lane enables for a 32-bit bus
  function automatic byte_en_t gen_be(input logic [2:0] size, input logic [1:0] lane);
    byte_en_t be;
    case (size)
      HSIZE_BYTE:  be = byte_en_t'(4'b0001 << lane);
      HSIZE_HWORD: be = byte_en_t'(4'b0011 << {lane[1], 1'b0});
      HSIZE_WORD:  be = '1;
      // Wider sizes are not legal here
      default:     be = '1;
    endcase
    return be;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////////////////////////////////////////

  // Only NONSEQ and SEQ carry a transfer
  always_comb
  begin
    case (HTRANS)
      HTRANS_NONSEQ, HTRANS_SEQ: xfer = HSEL;
      HTRANS_IDLE, HTRANS_BUSY:  xfer = 1'b0;
      default:                   xfer = 1'b0;
    endcase
  end

  // Word aligned offset and compare slot
  assign ofs     = {HADDR[DEC_W-1:2], 2'b00};
  assign cmp_ofs = ofs - DEC_W'(`TIMER_OFS_TIMECMP);
  assign cmp_num = cmp_ofs[DEC_W-1:3];

  always_comb
  begin
    case (ofs)
      DEC_W'(`TIMER_OFS_PRESCALE): sel_d = SEL_PRESCALE;
      DEC_W'(`TIMER_OFS_RESERVED): sel_d = SEL_NONE;
      // Pending bits are read only
      DEC_W'(`TIMER_OFS_IPENDING): sel_d = HWRITE ? SEL_NONE : SEL_IPENDING;
      DEC_W'(`TIMER_OFS_IENABLE):  sel_d = SEL_IENABLE;
      DEC_W'(`TIMER_OFS_TIME):     sel_d = SEL_TIME_LO;
      DEC_W'(`TIMER_OFS_TIME + 4): sel_d = SEL_TIME_HI;
      default:
      begin
        // Compare slots past the last timer fall through to none
        if (ofs >= DEC_W'(`TIMER_OFS_TIMECMP) && cmp_num < `TIMER_NUM)
          sel_d = SEL_TIMECMP;
        else
          sel_d = SEL_NONE;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Data phase registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      wr_q  <= 1'b0;
      rd_q  <= 1'b0;
      sel_q <= SEL_NONE;
    end
    else if (HREADY)
    begin
      wr_q  <= xfer & HWRITE;
      rd_q  <= xfer & ~HWRITE;
      sel_q <= sel_d;
    end
  end

  // Access details
  always_ff @(posedge HCLK)
  begin
    if (HREADY)
    begin
      idx_q <= timer_idx_t'(cmp_num);
      hi_q  <= HADDR[2];
      be_q  <= gen_be(HSIZE, HADDR[1:0]);
    end
  end

  // Write data is valid at the end of a ready data phase
  assign bus.wr    = wr_q & HREADY;
  assign bus.rd    = rd_q;
  assign bus.sel   = sel_q;
  assign bus.idx   = idx_q;
  assign bus.hi    = hi_q;
  assign bus.be    = be_q;
  assign bus.wdata = HWDATA;

  // Accepted transfers are no wider than the data bus
  a_size_legal: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (HREADY && xfer) |-> (HSIZE <= HSIZE_WORD));

endmodule : ahb_timer_decode

/* timer_execute.sv */
// Timer register file and counter
`timescale 1ns/1ps
`include "timer_config.svh"

module timer_execute (
  input  logic        HCLK,
  input  logic        HRESETn,
  timer_regbus_if.exe bus
);
  import timer_pkg::*;

  localparam int DW = $bits(word_t);

  // Control registers
  word_t       prescale_q;
  logic        enabled_q;
  logic        prescale_wr_q;
  timer_mask_t ienable_q;
  timer_mask_t ipending_q;

  // Prescaler
  word_t       prescale_cnt_q;
  logic        count_en_q;

  // Time base and compares
  time_t       time_q;
  time_t       timecmp_q [`TIMER_NUM];

  // Write strobes
  logic        wr_prescale;
  logic        wr_ienable;
  logic        wr_time_lo;
  logic        wr_time_hi;
  logic        wr_timecmp;

  // Take new bytes where the lane is enabled
  function automatic word_t merge_bytes(input word_t old_val, input word_t new_val,
                                        input byte_en_t be);
    word_t res;
    for (int n = 0; n < $bits(byte_en_t); n++)
      res[n*8 +: 8] = be[n] ? new_val[n*8 +: 8] : old_val[n*8 +: 8];
    return res;
  endfunction

  assign wr_prescale = bus.wr && (bus.sel == SEL_PRESCALE);
  assign wr_ienable  = bus.wr && (bus.sel == SEL_IENABLE);
  assign wr_time_lo  = bus.wr && (bus.sel == SEL_TIME_LO);
  assign wr_time_hi  = bus.wr && (bus.sel == SEL_TIME_HI);
  assign wr_timecmp  = bus.wr && (bus.sel == SEL_TIMECMP);

  ////////////////////////////////////////////////////////////////////////////
  // Control registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      prescale_q    <= '0;
      enabled_q     <= 1'b0;
      prescale_wr_q <= 1'b0;
      ienable_q     <= '0;
    end
    else
    begin
      // Pulse restarts the prescaler
      prescale_wr_q <= wr_prescale;
      if (wr_prescale)
      begin
        prescale_q <= merge_bytes(prescale_q, bus.wdata, bus.be);
        // First prescale write starts the time base
        enabled_q  <= 1'b1;
      end
      // Upper enable bits are dropped
      if (wr_ienable)
        ienable_q <= timer_mask_t'(merge_bytes(word_t'(ienable_q), bus.wdata, bus.be));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Prescaler and time base
  ////////////////////////////////////////////////////////////////////////////

  // Down-counter, one tick every prescale+1 cycles
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      prescale_cnt_q <= '0;
    else if (prescale_wr_q || prescale_cnt_q == '0)
      prescale_cnt_q <= prescale_q;
    else
      prescale_cnt_q <= prescale_cnt_q - 1'b1;
  end

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      count_en_q <= 1'b0;
    else
      count_en_q <= enabled_q && (prescale_cnt_q == '0);
  end

  // Bus writes win over the increment
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      time_q <= '0;
    else if (wr_time_lo)
      time_q[DW-1:0] <= merge_bytes(time_q[DW-1:0], bus.wdata, bus.be);
    else if (wr_time_hi)
      time_q[2*DW-1:DW] <= merge_bytes(time_q[2*DW-1:DW], bus.wdata, bus.be);
    else if (count_en_q)
      time_q <= time_q + 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compares and pending bits
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      for (int n = 0; n < `TIMER_NUM; n++)
        timecmp_q[n] <= '0;
      ipending_q <= '0;
    end
    else
    begin
      for (int n = 0; n < `TIMER_NUM; n++)
      begin
        if (wr_timecmp && bus.idx == timer_idx_t'(n))
        begin
          if (bus.hi)
            timecmp_q[n][2*DW-1:DW] <= merge_bytes(timecmp_q[n][2*DW-1:DW], bus.wdata, bus.be);
          else
            timecmp_q[n][DW-1:0] <= merge_bytes(timecmp_q[n][DW-1:0], bus.wdata, bus.be);
          // Rearm, clear takes priority over a match
          ipending_q[n] <= 1'b0;
        end
        else if (enabled_q && timecmp_q[n] <= time_q)
          ipending_q[n] <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read mux and interrupt
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (bus.sel)
      SEL_PRESCALE: bus.rdata = prescale_q;
      SEL_IPENDING: bus.rdata = word_t'(ipending_q);
      SEL_IENABLE:  bus.rdata = word_t'(ienable_q);
      SEL_TIME_LO:  bus.rdata = time_q[DW-1:0];
      SEL_TIME_HI:  bus.rdata = time_q[2*DW-1:DW];
      SEL_TIMECMP:  bus.rdata = bus.hi ? timecmp_q[bus.idx][2*DW-1:DW]
                                       : timecmp_q[bus.idx][DW-1:0];
      // Reserved and unmapped read as zero
      default:      bus.rdata = '0;
    endcase
  end

  assign bus.irq_any = |(ipending_q & ienable_q);

  // Decode filters out compare slots past the last timer
  a_cmp_idx: assert property (@(posedge HCLK) disable iff (!HRESETn)
    wr_timecmp |-> (bus.idx < `TIMER_NUM));

endmodule : timer_execute

/* timer_result.sv */
// AHB response and interrupt
`timescale 1ns/1ps

module timer_result (
  input  logic             HCLK,
  input  logic             HRESETn,
  timer_regbus_if.res      bus,
  output timer_pkg::word_t HRDATA,
  output logic             HREADYOUT,
  output logic             tint
);

  // Set in the second cycle of a read data phase
  logic rd_done_q;
  // First cycle of a read data phase
  logic rd_first;

  ////////////////////////////////////////////////////////////////////////////
  // Read wait state
  ////////////////////////////////////////////////////////////////////////////

  assign rd_first = bus.rd & ~rd_done_q;

  // One wait cycle per read
  assign HREADYOUT = ~rd_first;

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      rd_done_q <= 1'b0;
    else
      rd_done_q <= rd_first;
  end

  // Register value captured during the wait
  always_ff @(posedge HCLK)
  begin
    if (rd_first)
      HRDATA <= bus.rdata;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Interrupt
  ////////////////////////////////////////////////////////////////////////////

  // One cycle behind the pending and enable bits
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      tint <= 1'b0;
    else
      tint <= bus.irq_any;
  end

  // Decode holds rd until the wait ends
  a_one_wait: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !HREADYOUT |=> (HREADYOUT && bus.rd));

endmodule : timer_result

/* ahb_timer_top.sv */
// AHB3-Lite timer top level
`timescale 1ns/1ps
`include "timer_config.svh"

module ahb_timer_top (
  input  logic                     HCLK,
  input  logic                     HRESETn,

  // AHB3-Lite slave port
  input  logic                     HSEL,
  input  logic [`TIMER_ADDR_W-1:0] HADDR,
  input  timer_pkg::word_t         HWDATA,
  input  logic                     HWRITE,
  input  logic [2:0]               HSIZE,
  input  logic [1:0]               HTRANS,
  input  logic                     HREADY,
  output timer_pkg::word_t         HRDATA,
  output logic                     HREADYOUT,
  output logic                     HRESP,

  // Timer interrupt
  output logic                     tint
);

  // Block never signals an error
  localparam logic HRESP_OKAY = 1'b0;

  // Decoded access from decode to the register file and response
  timer_regbus_if bus ();

  ////////////////////////////////////////////////////////////////////////////
  // Units
  ////////////////////////////////////////////////////////////////////////////

  ahb_timer_decode u_decode (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .HSEL    (HSEL),
    .HADDR   (HADDR),
    .HWDATA  (HWDATA),
    .HWRITE  (HWRITE),
    .HSIZE   (HSIZE),
    .HTRANS  (HTRANS),
    .HREADY  (HREADY),
    .bus     (bus.dec)
  );

  timer_execute u_execute (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .bus     (bus.exe)
  );

  timer_result u_result (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .bus       (bus.res),
    .HRDATA    (HRDATA),
    .HREADYOUT (HREADYOUT),
    .tint      (tint)
  );

  assign HRESP = HRESP_OKAY;

endmodule : ahb_timer_top

/* tb_clock_gen.sv */
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen (
  output logic HCLK,
  output logic HRESETn
);

  // 4 ns period
  localparam realtime HALF_PERIOD = 2ns;

  // Free running clock, low at time zero
  initial
  begin
    HCLK = 1'b0;
    forever #(HALF_PERIOD) HCLK = ~HCLK;
  end

  // Reset held low for two rising edges
  initial
  begin
    HRESETn = 1'b0;
    repeat (2) @(posedge HCLK);
    #1 HRESETn = 1'b1;
  end

endmodule : tb_clock_gen

/* tb_ahb_timer.sv */
// AHB timer directed testbench
`timescale 1ns/1ps
`include "timer_config.svh"

module tb_ahb_timer;
  import timer_pkg::*;

  // Run limit, the tests need well under a thousand cycles
  localparam int MAX_CYCLES = 4000;
  localparam int DRIVE_DLY = 1;
  localparam logic [31:0] ADDR_CMP0 = `TIMER_OFS_TIMECMP;
  localparam logic [31:0] ADDR_CMP1 = `TIMER_OFS_TIMECMP + 8;
  localparam logic [31:0] ADDR_BAD  = `TIMER_OFS_TIMECMP + 8 * `TIMER_NUM;
  localparam word_t IEN_MASK = word_t'((1 << `TIMER_NUM) - 1);
  // Prescale and wait for the rate check
  localparam int TICK_DIV = 3;
  localparam int WAIT_CYCLES = 200;

  logic                     HCLK;
  logic                     HRESETn;
  logic                     HSEL;
  logic [`TIMER_ADDR_W-1:0] HADDR;
  word_t                    HWDATA;
  logic                     HWRITE;
  logic [2:0]               HSIZE;
  logic [1:0]               HTRANS;
  logic                     HREADY;
  word_t                    HRDATA;
  logic                     HREADYOUT;
  logic                     HRESP;
  logic                     tint;

  integer seed;
  int     pass_count = 0;
  int     fail_count = 0;
  int     cycles = 0;

  tb_clock_gen u_clk (
    .HCLK    (HCLK),
    .HRESETn (HRESETn)
  );

  ahb_timer_top u_dut (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (HSEL),
    .HADDR     (HADDR),
    .HWDATA    (HWDATA),
    .HWRITE    (HWRITE),
    .HSIZE     (HSIZE),
    .HTRANS    (HTRANS),
    .HREADY    (HREADY),
    .HRDATA    (HRDATA),
    .HREADYOUT (HREADYOUT),
    .HRESP     (HRESP),
    .tint      (tint)
  );

  // Single slave, so the bus ready is the slave ready
  assign HREADY = HREADYOUT;

  // Watchdog
  always @(posedge HCLK)
  begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("Timeout: run still going after %0d cycles", MAX_CYCLES);
      $display("*** FAILED ***");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks and bus helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input word_t exp, input word_t got);
    assert (got === exp)
    begin
      pass_count++;
    end
    else
    begin
      fail_count++;
      $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic check_range(input string name, input word_t lo, input word_t hi,
                             input word_t got);
    assert (got >= lo && got <= hi)
    begin
      pass_count++;
    end
    else
    begin
      fail_count++;
      $display("Fail at %0t ns: %s expected %0d..%0d got %0d", $time, name, lo, hi, got);
    end
  endtask

  // Expected word after a narrow write, per AHB lane rules
  function automatic word_t lane_merge(input word_t old_val, input word_t new_val,
                                       input logic [1:0] lo, input logic [2:0] size);
    word_t res;
    int    nbytes;
    int    first;
    res    = old_val;
    nbytes = 1 << size;
    // Transfers are aligned to their own size
    first  = (int'(lo) / nbytes) * nbytes;
    for (int b = 0; b < 4; b++)
      if (b >= first && b < first + nbytes)
        res[b*8 +: 8] = new_val[b*8 +: 8];
    return res;
  endfunction

  // Address phase, then one data phase with no wait
  task automatic ahb_write(input logic [31:0] addr, input word_t data, input logic [2:0] size);
    @(posedge HCLK);
    #DRIVE_DLY;
    HSEL   = 1'b1;
    HADDR  = addr;
    HWRITE = 1'b1;
    HSIZE  = size;
    HTRANS = HTRANS_NONSEQ;
    @(posedge HCLK);
    #DRIVE_DLY;
    HSEL   = 1'b0;
    HWRITE = 1'b0;
    HTRANS = HTRANS_IDLE;
    HWDATA = data;
    @(negedge HCLK);
    check_value("HREADYOUT", 1, word_t'(HREADYOUT));
    check_value("HRESP", 0, word_t'(HRESP));
  endtask

  // Word read, counting wait cycles in the data phase
  task automatic fetch_word(input logic [31:0] addr, output word_t data);
    int waits;
    waits = 0;
    @(posedge HCLK);
    #DRIVE_DLY;
    HSEL   = 1'b1;
    HADDR  = addr;
    HWRITE = 1'b0;
    HSIZE  = HSIZE_WORD;
    HTRANS = HTRANS_NONSEQ;
    @(posedge HCLK);
    #DRIVE_DLY;
    HSEL   = 1'b0;
    HTRANS = HTRANS_IDLE;
    @(negedge HCLK);
    while (!HREADYOUT && waits < 4)
    begin
      waits++;
      @(negedge HCLK);
    end
    check_value("read wait states", 1, word_t'(waits));
    check_value("HRESP", 0, word_t'(HRESP));
    data = HRDATA;
  endtask

  task automatic ahb_read(input logic [31:0] addr, input word_t exp);
    word_t got;
    fetch_word(addr, got);
    check_value($sformatf("HRDATA at %h", addr), exp, got);
  endtask

  // Poll the interrupt line at falling edges, bounded
  task automatic wait_tint(input logic level, input int limit);
    int n;
    n = 0;
    @(negedge HCLK);
    while (tint !== level && n < limit)
    begin
      n++;
      @(negedge HCLK);
    end
    check_value("tint", word_t'(level), word_t'(tint));
  endtask

  task automatic report_test(input string name, input int start);
    $display("Test %s done with %0d errors", name, fail_count - start);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic reset_readback();
    int    start;
    word_t val;
    start = fail_count;
    // Whole map reads zero out of reset
    for (int a = 0; a < ADDR_BAD; a += 4)
      ahb_read(a, '0);
    val = $random(seed);
    ahb_write(`TIMER_OFS_PRESCALE, val, HSIZE_WORD);
    ahb_read(`TIMER_OFS_PRESCALE, val);
    val = $random(seed);
    ahb_write(`TIMER_OFS_IENABLE, val, HSIZE_WORD);
    ahb_read(`TIMER_OFS_IENABLE, val & IEN_MASK);
    // Last compare, both halves
    val = $random(seed);
    ahb_write(ADDR_CMP0 + 16, val, HSIZE_WORD);
    ahb_read(ADDR_CMP0 + 16, val);
    val = $random(seed);
    ahb_write(ADDR_CMP0 + 20, val, HSIZE_WORD);
    ahb_read(ADDR_CMP0 + 20, val);
    report_test("reset_readback", start);
  endtask

  task automatic byte_lanes();
    int    start;
    word_t exp;
    word_t data;
    start = fail_count;
    exp = $random(seed);
    ahb_write(ADDR_CMP0, exp, HSIZE_WORD);
    // Byte in lane 1, other lanes carry junk
    data = $random(seed);
    ahb_write(ADDR_CMP0 + 1, data, HSIZE_BYTE);
    exp = lane_merge(exp, data, 2'd1, HSIZE_BYTE);
    ahb_read(ADDR_CMP0, exp);
    data = $random(seed);
    ahb_write(ADDR_CMP0 + 2, data, HSIZE_HWORD);
    exp = lane_merge(exp, data, 2'd2, HSIZE_HWORD);
    ahb_read(ADDR_CMP0, exp);
    data = $random(seed);
    ahb_write(ADDR_CMP0 + 3, data, HSIZE_BYTE);
    exp = lane_merge(exp, data, 2'd3, HSIZE_BYTE);
    ahb_read(ADDR_CMP0, exp);
    // Upper word, low halfword
    exp = $random(seed);
    ahb_write(ADDR_CMP0 + 4, exp, HSIZE_WORD);
    data = $random(seed);
    ahb_write(ADDR_CMP0 + 4, data, HSIZE_HWORD);
    exp = lane_merge(exp, data, 2'd0, HSIZE_HWORD);
    ahb_read(ADDR_CMP0 + 4, exp);
    report_test("byte_lanes", start);
  endtask

  task automatic ignored_addresses();
    int    start;
    word_t pre;
    start = fail_count;
    // Park every compare at the top so no pending bit can set
    for (int n = 0; n < `TIMER_NUM; n++)
    begin
      ahb_write(ADDR_CMP0 + 8*n, '1, HSIZE_WORD);
      ahb_write(ADDR_CMP0 + 8*n + 4, '1, HSIZE_WORD);
    end
    ahb_read(`TIMER_OFS_IPENDING, '0);
    ahb_write(`TIMER_OFS_IPENDING, '1, HSIZE_WORD);
    ahb_read(`TIMER_OFS_IPENDING, '0);
    fetch_word(`TIMER_OFS_PRESCALE, pre);
    // Reserved word
    ahb_read(`TIMER_OFS_RESERVED, '0);
    ahb_write(`TIMER_OFS_RESERVED, $random(seed), HSIZE_WORD);
    ahb_read(`TIMER_OFS_RESERVED, '0);
    // Compare slot past the last timer
    ahb_read(ADDR_BAD, '0);
    ahb_read(ADDR_BAD + 4, '0);
    ahb_write(ADDR_BAD, $random(seed), HSIZE_WORD);
    ahb_write(ADDR_BAD + 4, $random(seed), HSIZE_WORD);
    ahb_read(ADDR_BAD, '0);
    ahb_read(ADDR_BAD + 4, '0);
    // Nothing real moved
    ahb_read(ADDR_CMP0, '1);
    ahb_read(ADDR_CMP0 + 4, '1);
    ahb_read(`TIMER_OFS_PRESCALE, pre);
    report_test("ignored_addresses", start);
  endtask

  task automatic time_counting();
    int    start;
    int    ticks;
    word_t val;
    start = fail_count;
    ahb_write(`TIMER_OFS_PRESCALE, TICK_DIV, HSIZE_WORD);
    ahb_write(`TIMER_OFS_TIME + 4, '0, HSIZE_WORD);
    ahb_write(`TIMER_OFS_TIME, '0, HSIZE_WORD);
    repeat (WAIT_CYCLES) @(posedge HCLK);
    fetch_word(`TIMER_OFS_TIME, val);
    ticks = WAIT_CYCLES / (TICK_DIV + 1);
    check_range("time low", ticks - 2, ticks + 2, val);
    // Carry into the high word, one tick per cycle
    ahb_write(`TIMER_OFS_PRESCALE, '0, HSIZE_WORD);
    ahb_write(`TIMER_OFS_TIME + 4, 5, HSIZE_WORD);
    ahb_write(`TIMER_OFS_TIME, 32'hFFFF_FFF0, HSIZE_WORD);
    repeat (40) @(posedge HCLK);
    ahb_read(`TIMER_OFS_TIME + 4, 6);
    fetch_word(`TIMER_OFS_TIME, val);
    check_range("time low after wrap", 0, 'hFF, val);
    report_test("time_counting", start);
  endtask

  task automatic compare_interrupt();
    int    start;
    int    polls;
    word_t pend;
    start = fail_count;
    ahb_write(`TIMER_OFS_IENABLE, '0, HSIZE_WORD);
    ahb_write(`TIMER_OFS_TIME + 4, '0, HSIZE_WORD);
    ahb_write(`TIMER_OFS_TIME, '0, HSIZE_WORD);
    // Compare 1 at time 60, low word first keeps it out of reach meanwhile
    ahb_write(ADDR_CMP1, 60, HSIZE_WORD);
    ahb_write(ADDR_CMP1 + 4, '0, HSIZE_WORD);
    ahb_read(`TIMER_OFS_IPENDING, '0);
    polls = 0;
    pend = '0;
    while (pend[1] !== 1'b1 && polls < 60)
    begin
      polls++;
      fetch_word(`TIMER_OFS_IPENDING, pend);
    end
    check_value("ipending", 32'h2, pend);
    // Masked, so the line stays low
    @(negedge HCLK);
    check_value("tint", 0, word_t'(tint));
    ahb_write(`TIMER_OFS_IENABLE, 32'h2, HSIZE_WORD);
    wait_tint(1'b1, 8);
    // Move compare 1 far ahead, bit clears
    ahb_write(ADDR_CMP1 + 4, '1, HSIZE_WORD);
    wait_tint(1'b0, 8);
    ahb_read(`TIMER_OFS_IPENDING, '0);
    report_test("compare_interrupt", start);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    HSEL   = 1'b0;
    HADDR  = '0;
    HWDATA = '0;
    HWRITE = 1'b0;
    HSIZE  = HSIZE_WORD;
    HTRANS = HTRANS_IDLE;
    seed   = 32'heb7081c3;
    wait (HRESETn === 1'b1);
    reset_readback();
    byte_lanes();
    ignored_addresses();
    time_counting();
    compare_interrupt();
    @(posedge HCLK);
    $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule : tb_ahb_timer

/* build.f */
+incdir+.
timer_pkg.sv
timer_regbus_if.sv
ahb_timer_decode.sv
timer_execute.sv
timer_result.sv
ahb_timer_top.sv
tb_clock_gen.sv
tb_ahb_timer.sv
